// File: verilog.f
+incdir+include
verilog/median_pkg.sv
verilog/rank_cell.sv
verilog/rank_sorter.sv
verilog/frame_buffer.sv
verilog/window_scanner.sv
verilog/lmfe_top.sv
tb/tb_lmfe.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the median filter testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal --top-module tb_lmfe -f verilog.f -o tb_lmfe \
  > build.log 2>&1 \
  && ./obj_dir/tb_lmfe > sim.log 2>&1 \
  || echo "build or simulation stopped early, see build.log and sim.log" >> sim.log

cat sim.log
grep -q "TEST FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
exit 0

// File: include/median_ref.svh
/*
  median reference model
  copy of the driven frame and a zero padded 7x7 median
*/
`ifndef MEDIAN_REF_SVH
`define MEDIAN_REF_SVH

// frame as driven, indexed [row][col]
median_pkg::pixel_t ref_frame [median_pkg::IMG_H][median_pkg::IMG_W];

function automatic median_pkg::pixel_t ref_median(input int row, input int col);
  median_pkg::pixel_t win [median_pkg::WIN_AREA];
  median_pkg::pixel_t key;
  int idx;
  int y;
  int x;
  int j;

  idx = 0;
  // gather the window, zero outside the frame
  for (int dy = -median_pkg::WIN_R; dy <= median_pkg::WIN_R; dy++) begin
    for (int dx = -median_pkg::WIN_R; dx <= median_pkg::WIN_R; dx++) begin
      y = row + dy;
      x = col + dx;
      if (y >= 0 && y < median_pkg::IMG_H && x >= 0 && x < median_pkg::IMG_W) begin
        win[idx] = ref_frame[y][x];
      end else begin
        win[idx] = '0;
      end
      idx++;
    end
  end

  // insertion sort, ascending
  for (int i = 1; i < median_pkg::WIN_AREA; i++) begin
    key = win[i];
    j = i - 1;
    while (j >= 0 && win[j] > key) begin
      win[j+1] = win[j];
      j--;
    end
    win[j+1] = key;
  end

  return win[median_pkg::MED_RANK];
endfunction

`endif

// File: tb/tb_lmfe.sv
/*
  median filter testbench
  drives three frames into the filter and checks every median against
  a zero padded 7x7 reference, with stalls and input gaps
*/
`default_nettype none

module tb_lmfe import median_pkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  `include "median_ref.svh"

  // three frames, up to about 130 cycles per pixel under stalls
  localparam int TIMEOUT_CYCLES = 3 * FRAME_PIX * 130;

  logic   CLK;
  logic   RST;
  logic   in_valid;
  logic   in_ready;
  pixel_t in_data;
  logic   out_valid;
  logic   out_ready;
  pixel_t out_data;

  pixel_t exp_med [FRAME_PIX];
  int     in_cnt;
  int     out_cnt;
  int     total_meds;
  int     cycle_cnt;
  int     err_cnt;
  int     test_num;
  logic   busy;
  logic   ready_random;
  logic   flat_frame;

  lmfe_top u_lmfe_top (
    .CLK       (CLK),
    .RST       (RST),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

  initial begin
    CLK = 1'b0;
    forever begin
      #10 CLK = ~CLK;
    end
  end

  // output side, ready either held high or toggled at random
  initial begin
    out_ready = 1'b0;
    forever begin
      @(posedge CLK);
      #2;
      if (RST) begin
        out_ready = 1'b0;
      end else if (ready_random) begin
        out_ready = ($urandom_range(1) == 1);
      end else begin
        out_ready = 1'b1;
      end
    end
  end

  // transfer counters, busy spans last accepted pixel to last median
  always @(posedge CLK) begin
    if (RST) begin
      in_cnt  <= 0;
      out_cnt <= 0;
      busy    <= 1'b0;
    end else begin
      if (in_valid && in_ready) begin
        in_cnt <= (in_cnt == FRAME_PIX - 1) ? 0 : in_cnt + 1;
        if (in_cnt == FRAME_PIX - 1) begin
          busy <= 1'b1;
        end
      end
      if (out_valid && out_ready) begin
        total_meds <= total_meds + 1;
        out_cnt    <= (out_cnt == FRAME_PIX - 1) ? 0 : out_cnt + 1;
        if (out_cnt == FRAME_PIX - 1) begin
          busy <= 1'b0;
        end
      end
    end
  end

  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  a_reset_state: assert property (@(posedge CLK) $fell(RST) |-> (!out_valid && in_ready))
    else begin
      $display("CHECK FAILED t=%0t: after reset out_valid %b in_ready %b",
               $time, $sampled(out_valid), $sampled(in_ready));
      err_cnt = err_cnt + 1;
    end

  a_median: assert property (@(posedge CLK) disable iff (RST)
    (out_valid && out_ready) |-> (out_data == exp_med[out_cnt]))
    else begin
      $display("CHECK FAILED t=%0t: median %0d got %0d expected %0d", $time,
               $sampled(out_cnt), $sampled(out_data), exp_med[$sampled(out_cnt)]);
      err_cnt = err_cnt + 1;
    end

  a_stall_hold: assert property (@(posedge CLK) disable iff (RST)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
    else begin
      $display("CHECK FAILED t=%0t: stalled median changed to %0d", $time,
               $sampled(out_data));
      err_cnt = err_cnt + 1;
    end

  a_ready_low: assert property (@(posedge CLK) disable iff (RST) busy |-> !in_ready)
    else begin
      $display("CHECK FAILED t=%0t: in_ready high with medians pending", $time);
      err_cnt = err_cnt + 1;
    end

  a_ready_back: assert property (@(posedge CLK) disable iff (RST)
    (out_valid && out_ready && out_cnt == FRAME_PIX - 1) |=> in_ready)
    else begin
      $display("CHECK FAILED t=%0t: in_ready low after last median", $time);
      err_cnt = err_cnt + 1;
    end

  // no median outside the 256 of a frame
  a_no_extra: assert property (@(posedge CLK) disable iff (RST) out_valid |-> busy)
    else begin
      $display("CHECK FAILED t=%0t: median offered with no frame pending", $time);
      err_cnt = err_cnt + 1;
    end

  a_flat_corner: assert property (@(posedge CLK) disable iff (RST)
    (out_valid && out_ready && flat_frame && out_cnt == 0) |-> (out_data == 8'h00))
    else begin
      $display("CHECK FAILED t=%0t: flat frame corner got %0d expected 0", $time,
               $sampled(out_data));
      err_cnt = err_cnt + 1;
    end

  task automatic build_expected();
    for (int r = 0; r < IMG_H; r++) begin
      for (int c = 0; c < IMG_W; c++) begin
        exp_med[r * IMG_W + c] = ref_median(r, c);
      end
    end
  endtask

  task automatic load_frame(input bit gaps, input bit flat);
    int     n;
    logic   drive;
    pixel_t pix;

    n = 0;
    while (n < FRAME_PIX) begin
      pix      = flat ? PIX_MAX : pixel_t'($urandom);
      drive    = gaps ? ($urandom_range(3) != 0) : 1'b1;
      in_valid = drive;
      in_data  = pix;
      // in_ready only moves on an edge, so this matches the next edge
      if (drive && in_ready) begin
        ref_frame[n / IMG_W][n % IMG_W] = pix;
        n++;
      end
      @(posedge CLK);
      #2;
    end
    in_valid = 1'b0;
    build_expected();
  endtask

  task automatic run_frame(input string name, input bit gaps, input bit flat,
                           input bit stall);
    int first;

    first        = total_meds;
    ready_random = stall;
    flat_frame   = flat;
    load_frame(gaps, flat);
    while (busy) begin
      @(posedge CLK);
    end
    repeat (2) @(posedge CLK);
    #2;
    test_num++;
    $display("test %0d %s done, %0d medians", test_num, name, total_meds - first);
  endtask

  initial begin
    void'($urandom(32'hce22));
    RST          = 1'b1;
    in_valid     = 1'b0;
    in_data      = '0;
    ready_random = 1'b0;
    flat_frame   = 1'b0;
    err_cnt      = 0;
    test_num     = 0;
    total_meds   = 0;
    cycle_cnt    = 0;
    repeat (2) @(posedge CLK);
    #2;
    RST = 1'b0;
    repeat (2) @(posedge CLK);
    #2;
    test_num++;
    $display("test %0d reset_state done", test_num);

    run_frame("random_frame", 1'b0, 1'b0, 1'b0);
    run_frame("stalls_and_gaps", 1'b1, 1'b0, 1'b1);
    run_frame("flat_frame", 1'b0, 1'b1, 1'b0);

    $display("tests %0d, medians checked %0d, checks failed %0d",
             test_num, total_meds, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/lmfe_top.sv
/*
  median filter top
  scanner, frame buffer and rank sorter for a 7x7 median over one frame
*/
`default_nettype none

module lmfe_top import median_pkg::*; (
  input  logic   CLK,
  input  logic   RST,
  input  logic   in_valid,
  output logic   in_ready,
  input  pixel_t in_data,
  output logic   out_valid,
  input  logic   out_ready,
  output pixel_t out_data
);

  logic      wr_en;
  addr_t     wr_addr;
  pixel_t    wr_data;
  rd_req_t   rd_req;
  pixel_t    ins_q;
  pixel_t    del_q;
  sort_cmd_t sort_cmd;
  pixel_t    median;

  window_scanner u_window_scanner (
    .CLK       (CLK),
    .RST       (RST),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_req    (rd_req),
    .ins_q     (ins_q),
    .del_q     (del_q),
    .sort_cmd  (sort_cmd),
    .median    (median)
  );

  frame_buffer u_frame_buffer (
    .CLK     (CLK),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_req  (rd_req),
    .ins_q   (ins_q),
    .del_q   (del_q)
  );

  rank_sorter u_rank_sorter (
    .CLK      (CLK),
    .RST      (RST),
    .sort_cmd (sort_cmd),
    .median   (median)
  );

endmodule

`default_nettype wire

// File: verilog/window_scanner.sv
/*
  window scanner
  loads a frame, walks the output pixels in raster order and feeds the
  sorter one insert/delete pair per read, then hands out each median
*/
`default_nettype none

module window_scanner import median_pkg::*; (
  input  logic      CLK,
  input  logic      RST,
  input  logic      in_valid,
  output logic      in_ready,
  input  pixel_t    in_data,
  output logic      out_valid,
  input  logic      out_ready,
  output pixel_t    out_data,
  output logic      wr_en,
  output addr_t     wr_addr,
  output pixel_t    wr_data,
  output rd_req_t   rd_req,
  input  pixel_t    ins_q,
  input  pixel_t    del_q,
  output sort_cmd_t sort_cmd,
  input  pixel_t    median
);

  scan_state_t state;
  addr_t       load_cnt;
  addr_t       out_pos;
  logic [5:0]  step_cnt;
  logic [2:0]  off_r;
  logic [2:0]  off_c;

  coord_t pos_y;
  coord_t pos_x;
  coord_t ins_y;
  coord_t ins_x;
  coord_t del_x;
  logic   ins_in;
  logic   del_in;

  logic fill_rd;
  logic rd_act;
  logic load_last;
  logic settle_done;
  logic emit_take;

  // read side flags, one cycle behind to meet the returned data
  logic upd_pend;
  logic upd_fill;
  logic ins_in_d;
  logic del_in_d;

  // input side
  assign in_ready  = (state == ST_LOAD);
  assign wr_en     = in_valid && in_ready;
  assign wr_addr   = load_cnt;
  assign wr_data   = in_data;
  assign load_last = wr_en && (load_cnt == addr_t'(FRAME_PIX - 1));

  // output side
  assign out_valid = (state == ST_EMIT);
  assign emit_take = out_valid && out_ready;

  assign fill_rd     = (state == ST_FILL) && (step_cnt != '0);
  assign rd_act      = fill_rd || (state == ST_SLIDE);
  assign settle_done = (state == ST_SETTLE) && (step_cnt == 6'd1);

  // window coordinates around the current output pixel
  assign pos_y = coord_t'({2'b00, out_pos[7:4]});
  assign pos_x = coord_t'({2'b00, out_pos[3:0]});
  assign ins_y = pos_y + coord_t'({3'b000, off_r}) - coord_t'(WIN_R);

  // slide brings in the right column, fill walks the whole window
  assign ins_x = (state == ST_SLIDE) ? pos_x + coord_t'(WIN_R) :
                 pos_x + coord_t'({3'b000, off_c}) - coord_t'(WIN_R);
  assign del_x = pos_x - coord_t'(WIN_R + 1);

  assign ins_in = (ins_y >= 0) && (ins_y < IMG_H) && (ins_x >= 0) && (ins_x < IMG_W);
  assign del_in = (ins_y >= 0) && (ins_y < IMG_H) && (del_x >= 0);

  always_comb begin
    rd_req.ins_addr = {ins_y[3:0], ins_x[3:0]};
    rd_req.del_addr = {ins_y[3:0], del_x[3:0]};
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      upd_pend <= 1'b0;
      upd_fill <= 1'b0;
      ins_in_d <= 1'b0;
      del_in_d <= 1'b0;
    end else begin
      upd_pend <= rd_act;
      upd_fill <= (state == ST_FILL);
      ins_in_d <= ins_in;
      del_in_d <= del_in;
    end
  end

  // sorter command, out of frame pixels count as zero
  always_comb begin
    sort_cmd.op  = SORT_IDLE;
    sort_cmd.ins = PIX_MAX;
    sort_cmd.del = PIX_MAX;
    if ((state == ST_FILL) && (step_cnt == '0)) begin
      sort_cmd.op = SORT_CLEAR;
    end else if (upd_pend) begin
      sort_cmd.op  = SORT_UPDATE;
      sort_cmd.ins = ins_in_d ? ins_q : '0;
      if (!upd_fill) begin
        sort_cmd.del = del_in_d ? del_q : '0;
      end
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= ST_LOAD;
      load_cnt <= '0;
      out_pos  <= '0;
      step_cnt <= '0;
      off_r    <= '0;
      off_c    <= '0;
    end else begin
      case (state)
        ST_LOAD: begin
          if (wr_en) begin
            load_cnt <= load_cnt + 1'b1;
          end
          if (load_last) begin
            state    <= ST_FILL;
            step_cnt <= '0;
          end
        end
        ST_FILL: begin
          // step 0 clears, steps 1..49 read the window
          step_cnt <= step_cnt + 1'b1;
          if (fill_rd) begin
            if (off_c == 3'(WIN - 1)) begin
              off_c <= '0;
              off_r <= off_r + 1'b1;
            end else begin
              off_c <= off_c + 1'b1;
            end
          end
          if (step_cnt == 6'(WIN_AREA)) begin
            state    <= ST_SETTLE;
            step_cnt <= '0;
          end
        end
        ST_SLIDE: begin
          step_cnt <= step_cnt + 1'b1;
          off_r    <= off_r + 1'b1;
          if (step_cnt == 6'(WIN - 1)) begin
            state    <= ST_SETTLE;
            step_cnt <= '0;
          end
        end
        ST_SETTLE: begin
          // last update lands, then one cycle for the median
          step_cnt <= step_cnt + 1'b1;
          if (settle_done) begin
            state <= ST_EMIT;
          end
        end
        ST_EMIT: begin
          if (emit_take) begin
            out_pos  <= out_pos + 1'b1;
            step_cnt <= '0;
            off_r    <= '0;
            off_c    <= '0;
            if (out_pos == addr_t'(FRAME_PIX - 1)) begin
              state <= ST_LOAD;
            end else if (out_pos[3:0] == 4'(IMG_W - 1)) begin
              state <= ST_FILL;
            end else begin
              state <= ST_SLIDE;
            end
          end
        end
        default: begin
          state <= ST_LOAD;
        end
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (settle_done) begin
      out_data <= median;
    end
  end

  // held median must survive a stall
  a_out_stable: assert property (@(posedge CLK) disable iff (RST)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data)));

endmodule

`default_nettype wire

// File: verilog/frame_buffer.sv
/*
  frame buffer
  one full frame of pixels, single write port and two registered read ports
*/
`default_nettype none

module frame_buffer import median_pkg::*; (
  input  logic    CLK,
  input  logic    wr_en,
  input  addr_t   wr_addr,
  input  pixel_t  wr_data,
  input  rd_req_t rd_req,
  output pixel_t  ins_q,
  output pixel_t  del_q
);

  pixel_t mem [FRAME_PIX];

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // entering pixel
  always_ff @(posedge CLK) begin
    ins_q <= mem[rd_req.ins_addr];
  end

  // departing pixel, read again instead of kept in a window array
  always_ff @(posedge CLK) begin
    del_q <= mem[rd_req.del_addr];
  end

endmodule

`default_nettype wire

// File: verilog/rank_sorter.sv
/*
  rank sorter
  chain of rank cells holding the window in sorted order,
  decodes the sorter command and taps the middle cell as the median
*/
`default_nettype none

module rank_sorter import median_pkg::*; (
  input  logic      CLK,
  input  logic      RST,
  input  sort_cmd_t sort_cmd,
  output pixel_t    median
);

  logic   chain_clear;
  pixel_t chain_ins;
  pixel_t chain_del;

  // slot i lives at chain[i+1], both ends are fixed bounds
  pixel_t chain [0:WIN_AREA+1];

  always_comb begin
    chain_clear = 1'b0;
    chain_ins   = PIX_MAX;
    chain_del   = PIX_MAX;
    case (sort_cmd.op)
      SORT_CLEAR: begin
        chain_clear = 1'b1;
      end
      SORT_UPDATE: begin
        chain_ins = sort_cmd.ins;
        chain_del = sort_cmd.del;
      end
      default: begin
        // equal pair, nothing moves
        chain_clear = 1'b0;
      end
    endcase
  end

  assign chain[0]          = '0;
  assign chain[WIN_AREA+1] = PIX_MAX;

  for (genvar i = 0; i < WIN_AREA; i++) begin : g_cell
    rank_cell u_rank_cell (
      .CLK   (CLK),
      .RST   (RST),
      .clear (chain_clear),
      .ins   (chain_ins),
      .del   (chain_del),
      .prev  (chain[i]),
      .next  (chain[i+2]),
      .value (chain[i+1])
    );

    if (i > 0) begin : g_order
      // neighbouring slots never cross
      a_sorted: assert property (@(posedge CLK) disable iff (RST)
        chain[i] <= chain[i+1]);
    end
  end

  assign median = chain[MED_RANK+1];

endmodule

`default_nettype wire

// File: verilog/rank_cell.sv
/*
  rank cell
  one slot of the sorted window, shifts on an insert/delete pair
*/
`default_nettype none

module rank_cell import median_pkg::*; (
  input  logic   CLK,
  input  logic   RST,
  input  logic   clear,
  input  pixel_t ins,
  input  pixel_t del,
  input  pixel_t prev,
  input  pixel_t next,
  output pixel_t value
);

  pixel_t value_nxt;

  always_comb begin
    value_nxt = value;
    if (ins < del) begin
      // new value lands below, slots in (ins, del] move up one
      if (value > ins && value <= del) begin
        value_nxt = (prev > ins) ? prev : ins;
      end
    end else if (ins > del) begin
      // mirrored, slots in [del, ins) move down one
      if (value < ins && value >= del) begin
        value_nxt = (next < ins) ? next : ins;
      end
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      value <= PIX_MAX;
    end else if (clear) begin
      value <= PIX_MAX;
    end else begin
      value <= value_nxt;
    end
  end

  // decoder must park the pair on a clear
  a_clear_no_update: assert property (@(posedge CLK) disable iff (RST)
    clear |-> (ins == del));

endmodule

`default_nettype wire

// File: verilog/median_pkg.sv
/*
  median filter package
  frame geometry, pixel and address types, sorter command and scan state
*/
`default_nettype none

package median_pkg;

  // frame geometry
  localparam int IMG_W     = 16;
  localparam int IMG_H     = 16;
  localparam int FRAME_PIX = IMG_W * IMG_H;

  // window geometry
  localparam int WIN      = 7;
  localparam int WIN_R    = 3;
  localparam int WIN_AREA = WIN * WIN;
  localparam int MED_RANK = WIN_AREA / 2;

  // empty slot value, also the delete value while filling
  localparam logic [7:0] PIX_MAX = 8'hff;

  typedef logic [7:0] pixel_t;

  // row in the high nibble, column in the low nibble
  typedef logic [7:0] addr_t;

  // signed so window positions left of or above the frame stay negative
  typedef logic signed [5:0] coord_t;

  typedef enum logic [1:0] {
    SORT_IDLE,
    SORT_CLEAR,
    SORT_UPDATE
  } sort_op_t;

  typedef struct packed {
    sort_op_t op;
    pixel_t   ins;
    pixel_t   del;
  } sort_cmd_t;

  typedef struct packed {
    addr_t ins_addr;
    addr_t del_addr;
  } rd_req_t;

  typedef enum logic [2:0] {
    ST_LOAD,
    ST_FILL,
    ST_SLIDE,
    ST_SETTLE,
    ST_EMIT
  } scan_state_t;

endpackage

`default_nettype wire
